/* sentry_dcache_req.f */
+incdir+include
rtl/sentry_pkg.sv
rtl/trace_frame_fifo.sv
rtl/lane_decoder.sv
rtl/shadow_reg_file.sv
rtl/dcache_req_gen.sv
rtl/sentry_dcache_req.sv
test/sentry_checker.sv
test/tb_sentry_dcache_req.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sentry_dcache_req
FILELIST   := sentry_dcache_req.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, the simulator exits cleanly either way
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_sentry_dcache_req.sv */
// frames come from a fixed table plus random back-pressure frames; the source never writes while full
`timescale 1ns/1ps
`default_nettype none

`include "sentry_cfg.svh"

module tb_sentry_dcache_req;

    localparam int max_hold = 6;

    logic                     clk;
    logic                     rst;
    logic                     frame_valid;
    sentry_pkg::trace_frame_t frame_in;
    logic                     fifo_full;
    logic                     dcache_almost_full;
    logic [`SENTRY_LANES-1:0] req_valid;
    logic [`SENTRY_LANES-1:0] req_store;
    sentry_pkg::data_t        req_address [`SENTRY_LANES-1:0];
    logic                     inst_valid;

    // lanes of entry e sit at t_rec[LANES*e + lane]
    string                    t_name [$];
    int                       t_hold [$];
    sentry_pkg::trace_rec_t   t_rec  [$];
    sentry_pkg::data_t        model_regs [`SENTRY_NREGS];
    int                       cycles      = 0;
    int                       cycle_limit = 0;
    int                       bp_left     = 0;
    int                       idle_errors = 0;

    sentry_dcache_req u_dut (
        .clk                (clk),
        .rst                (rst),
        .frame_valid        (frame_valid),
        .frame_in           (frame_in),
        .fifo_full          (fifo_full),
        .dcache_almost_full (dcache_almost_full),
        .dcache_req_valid   (req_valid),
        .dcache_req_store   (req_store),
        .dcache_req_address (req_address),
        .dcache_inst_valid  (inst_valid)
    );

    sentry_checker u_chk (
        .clk                (clk),
        .rst                (rst),
        .dcache_almost_full (dcache_almost_full),
        .dcache_req_valid   (req_valid),
        .dcache_req_store   (req_store),
        .dcache_req_address (req_address),
        .dcache_inst_valid  (inst_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("timeout after %0d cycles, %0d frames never issued", cycles, u_chk.pending());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ************************************************************
    // instruction encoders and table building
    // ************************************************************
    function automatic sentry_pkg::inst_t enc_i(input logic [6:0] opc, input int rd,
                                                input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], opc};
    endfunction

    function automatic sentry_pkg::inst_t enc_s(input logic [6:0] opc, input int rs1,
                                                input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc};
    endfunction

    task automatic add_entry(input string name, input int hold);
        t_name.push_back(name);
        t_hold.push_back(hold);
    endtask

    task automatic add_lane(input sentry_pkg::inst_t inst, input sentry_pkg::data_t result,
                            input sentry_pkg::data_t pc);
        t_rec.push_back(sentry_pkg::trace_rec_t'{inst, result, pc});
    endtask

    task automatic build_table();
        add_entry("alu_setup", 0);
        add_lane(enc_i(sentry_pkg::OPC_OP_IMM, 1, 0, 0), 32'h0000_1000, 32'h100);
        add_lane(enc_i(sentry_pkg::OPC_LUI, 2, 0, 0), 32'h2000_0000, 32'h104);
        add_lane(enc_i(sentry_pkg::OPC_OP, 3, 1, 0), 32'h0000_0400, 32'h108);
        add_lane(enc_i(sentry_pkg::OPC_AUIPC, 4, 0, 0), 32'h0000_8000, 32'h10c);
        add_entry("loads", 0);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 5, 1, 4), 32'h55, 32'h110);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 6, 2, -8), 32'h66, 32'h114);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 7, 3, 12'h7ff), 32'h77, 32'h118);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 8, 4, -2048), 32'h88, 32'h11c);
        add_entry("stores_mixed", 0);
        add_lane(enc_s(sentry_pkg::OPC_STORE, 1, 5, 12), 32'h0, 32'h120);
        add_lane(enc_s(sentry_pkg::OPC_STORE, 3, 2, -4), 32'h0, 32'h124);
        add_lane(enc_s(sentry_pkg::OPC_BRANCH, 1, 2, 16), 32'h0, 32'h128);
        add_lane(enc_i(sentry_pkg::OPC_OP, 20, 1, 0), 32'h0000_1400, 32'h12c);
        add_entry("jal_link", 0);
        add_lane(enc_i(sentry_pkg::OPC_JAL, 9, 0, 0), 32'hdead_beef, 32'h4000);
        add_lane(enc_i(sentry_pkg::OPC_JALR, 10, 1, 0), 32'hdead_beef, 32'h5000);
        add_lane(enc_i(sentry_pkg::OPC_OP_IMM, 11, 0, 0), 32'h0000_0300, 32'h5004);
        add_lane(enc_i(sentry_pkg::OPC_OP_IMM, 0, 0, 0), 32'h0000_1234, 32'h5008);
        add_entry("link_loads", 0);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 12, 9, 0), 32'h12, 32'h500c);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 13, 10, 8), 32'h13, 32'h5010);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 14, 0, 12'h40), 32'h14, 32'h5014);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 15, 20, -16), 32'h15, 32'h5018);
        add_entry("same_frame", 0);
        add_lane(enc_i(sentry_pkg::OPC_OP_IMM, 16, 0, 0), 32'h0000_7000, 32'h501c);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 18, 16, 4), 32'h18, 32'h5020);
        add_lane(enc_i(sentry_pkg::OPC_OP_IMM, 17, 0, 0), 32'h0000_0111, 32'h5024);
        add_lane(enc_i(sentry_pkg::OPC_OP_IMM, 17, 0, 0), 32'h0000_0222, 32'h5028);
        add_entry("dup_check", 0);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 19, 16, 0), 32'h19, 32'h502c);
        add_lane(enc_i(sentry_pkg::OPC_LOAD, 21, 17, 0), 32'h21, 32'h5030);
        add_lane(enc_s(sentry_pkg::OPC_STORE, 17, 16, 8), 32'h0, 32'h5034);
        add_lane(enc_s(sentry_pkg::OPC_STORE, 0, 1, 12'h20), 32'h0, 32'h5038);
        // random memory frames queued up behind back-pressure
        for (int k = 0; k < 4; k++) begin
            add_entry($sformatf("backpressure_%0d", k), max_hold);
            for (int l = 0; l < `SENTRY_LANES; l++) begin
                if ($urandom_range(1, 0) == 1) begin
                    add_lane(enc_s(sentry_pkg::OPC_STORE, int'($urandom_range(21, 0)), 1,
                                   int'($urandom_range(4095, 0))), 32'h0, 32'h6000);
                end else begin
                    add_lane(enc_i(sentry_pkg::OPC_LOAD, 22 + l, int'($urandom_range(21, 0)),
                                   int'($urandom_range(4095, 0))), $urandom, 32'h6000);
                end
            end
        end
    endtask

    // ************************************************************
    // reference model: pre-frame reads, then lane-order writes
    // ************************************************************
    task automatic model_frame(input int e);
        sentry_pkg::trace_rec_t                r;
        logic [6:0]                            opc;
        sentry_pkg::data_t                     imm;
        logic [`SENTRY_LANES-1:0]              v;
        logic [`SENTRY_LANES-1:0]              s;
        logic [`SENTRY_LANES*`SENTRY_XLEN-1:0] addr;
        v    = '0;
        s    = '0;
        addr = '0;
        for (int l = 0; l < `SENTRY_LANES; l++) begin
            r   = t_rec[`SENTRY_LANES*e + l];
            opc = r.inst[6:0];
            if (opc == sentry_pkg::OPC_LOAD) begin
                imm = {{20{r.inst[31]}}, r.inst[31:20]};
            end else begin
                imm = {{20{r.inst[31]}}, r.inst[31:25], r.inst[11:7]};
            end
            v[l] = (opc == sentry_pkg::OPC_LOAD) || (opc == sentry_pkg::OPC_STORE);
            s[l] = (opc == sentry_pkg::OPC_STORE);
            addr[l*`SENTRY_XLEN +: `SENTRY_XLEN] = model_regs[r.inst[19:15]] + imm;
        end
        for (int l = 0; l < `SENTRY_LANES; l++) begin
            r   = t_rec[`SENTRY_LANES*e + l];
            opc = r.inst[6:0];
            if ((r.inst[11:7] != 5'd0) && (opc inside {sentry_pkg::OPC_LUI,
                    sentry_pkg::OPC_AUIPC, sentry_pkg::OPC_OP, sentry_pkg::OPC_OP_IMM,
                    sentry_pkg::OPC_LOAD})) begin
                model_regs[r.inst[11:7]] = r.result;
            end else if ((r.inst[11:7] != 5'd0) && ((opc == sentry_pkg::OPC_JAL) ||
                         (opc == sentry_pkg::OPC_JALR))) begin
                model_regs[r.inst[11:7]] = r.pc + 32'd4;
            end
        end
        u_chk.push_expected(t_name[e], v, s, addr);
    endtask

    // one clock step, with back-pressure counted down
    task automatic next_cycle();
        @(posedge clk);
        #1;
        dcache_almost_full = (bp_left > 0);
        if (bp_left > 0) begin
            bp_left--;
        end
    endtask

    initial begin
        sentry_pkg::trace_frame_t f;
        int                       gap;
        int                       total_errors;
        void'($urandom(32'he38aad75));
        rst                = 1'b1;
        frame_valid        = 1'b0;
        frame_in           = '0;
        dcache_almost_full = 1'b0;
        for (int r = 0; r < `SENTRY_NREGS; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        cycle_limit = t_name.size() * (max_hold + 4) + 20;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle outputs right after reset
        repeat (4) begin
            @(posedge clk);
            #1;
            if (inst_valid || (req_valid != '0) || (req_store != '0) || fifo_full) begin
                $display("error: output active after reset with no frames driven");
                idle_errors++;
            end
        end
        $display("test idle_after_reset: %s", (idle_errors == 0) ? "ok" : "failed");

        for (int e = 0; e < t_name.size(); e++) begin
            if (t_hold[e] > 0) begin
                gap = int'($urandom_range(t_hold[e], 1));
                if (gap > bp_left) begin
                    bp_left = gap;
                end
            end
            next_cycle();
            while (fifo_full) begin
                frame_valid = 1'b0;
                next_cycle();
            end
            for (int l = 0; l < `SENTRY_LANES; l++) begin
                f[l] = t_rec[`SENTRY_LANES*e + l];
            end
            frame_in    = f;
            frame_valid = 1'b1;
            model_frame(e);
        end
        next_cycle();
        frame_valid = 1'b0;
        while (bp_left > 0) begin
            next_cycle();
        end
        next_cycle();
        while (u_chk.pending() > 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        total_errors = u_chk.errors + idle_errors;
        $display("summary: %0d tests run, %0d errors", u_chk.tests_done + 1, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/sentry_checker.sv */
// compares each issued frame with the next expected one; addresses are checked on valid lanes only
`timescale 1ns/1ps
`default_nettype none

`include "sentry_cfg.svh"

module sentry_checker (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     dcache_almost_full,
    input wire logic [`SENTRY_LANES-1:0] dcache_req_valid,
    input wire logic [`SENTRY_LANES-1:0] dcache_req_store,
    input wire sentry_pkg::data_t        dcache_req_address [`SENTRY_LANES-1:0],
    input wire logic                     dcache_inst_valid
);

    string                                 exp_name  [$];
    logic [`SENTRY_LANES-1:0]              exp_valid [$];
    logic [`SENTRY_LANES-1:0]              exp_store [$];
    logic [`SENTRY_LANES*`SENTRY_XLEN-1:0] exp_addr  [$];
    int                                    errors     = 0;
    int                                    tests_done = 0;
    logic                                  bp_seen    = 1'b0;

    task automatic push_expected(input string name, input logic [`SENTRY_LANES-1:0] valid,
                                 input logic [`SENTRY_LANES-1:0] store,
                                 input logic [`SENTRY_LANES*`SENTRY_XLEN-1:0] addr);
        exp_name.push_back(name);
        exp_valid.push_back(valid);
        exp_store.push_back(store);
        exp_addr.push_back(addr);
    endtask

    function automatic int pending();
        return exp_name.size();
    endfunction

    // outputs change on the rising edge, so they are sampled on the falling one
    always @(negedge clk) begin
        string                                 name;
        logic [`SENTRY_LANES-1:0]              v;
        logic [`SENTRY_LANES-1:0]              s;
        logic [`SENTRY_LANES*`SENTRY_XLEN-1:0] a;
        int                                    bad;
        if (!rst) begin
            if (dcache_inst_valid && bp_seen) begin
                $display("error: frame issued while dcache_almost_full was high");
                errors++;
            end
            if (!dcache_inst_valid && ((dcache_req_valid | dcache_req_store) != '0)) begin
                $display("error: request strobe high without dcache_inst_valid");
                errors++;
            end
            if (dcache_inst_valid && (exp_name.size() == 0)) begin
                $display("error: dcache_inst_valid seen with no frame expected");
                errors++;
            end else if (dcache_inst_valid) begin
                name = exp_name.pop_front();
                v    = exp_valid.pop_front();
                s    = exp_store.pop_front();
                a    = exp_addr.pop_front();
                bad  = 0;
                if (dcache_req_valid !== v) begin
                    $display("MISMATCH %s req_valid expected %b actual %b", name, v,
                             dcache_req_valid);
                    bad++;
                end
                if (dcache_req_store !== s) begin
                    $display("MISMATCH %s req_store expected %b actual %b", name, s,
                             dcache_req_store);
                    bad++;
                end
                for (int l = 0; l < `SENTRY_LANES; l++) begin
                    if (v[l] && (dcache_req_address[l] !== a[l*`SENTRY_XLEN +: `SENTRY_XLEN])) begin
                        $display("MISMATCH %s lane %0d address expected %h actual %h", name, l,
                                 a[l*`SENTRY_XLEN +: `SENTRY_XLEN], dcache_req_address[l]);
                        bad++;
                    end
                end
                errors += bad;
                tests_done++;
                $display("test %s: %s", name, (bad == 0) ? "ok" : "failed");
            end
        end
        bp_seen = dcache_almost_full;
    end

endmodule

`default_nettype wire

/* rtl/sentry_dcache_req.sv */
// no ready on the trace port; the source must hold frame_valid low while fifo_full is high
`timescale 1ns/1ps
`default_nettype none

`include "sentry_cfg.svh"

module sentry_dcache_req (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     frame_valid,
    input  wire sentry_pkg::trace_frame_t frame_in,
    output logic                          fifo_full,
    input  wire logic                     dcache_almost_full,
    output logic [`SENTRY_LANES-1:0]      dcache_req_valid,
    output logic [`SENTRY_LANES-1:0]      dcache_req_store,
    output sentry_pkg::data_t             dcache_req_address [`SENTRY_LANES-1:0],
    output logic                          dcache_inst_valid
);

    sentry_pkg::trace_frame_t head;
    logic                     fifo_empty;
    logic                     pop;

    sentry_pkg::reg_t         rs1       [`SENTRY_LANES-1:0];
    sentry_pkg::reg_t         rd        [`SENTRY_LANES-1:0];
    sentry_pkg::data_t        offset    [`SENTRY_LANES-1:0];
    sentry_pkg::data_t        wr_data   [`SENTRY_LANES-1:0];
    sentry_pkg::data_t        rs1_val   [`SENTRY_LANES-1:0];
    logic [`SENTRY_LANES-1:0] is_load;
    logic [`SENTRY_LANES-1:0] is_store;
    logic [`SENTRY_LANES-1:0] writes_rd;

    // ***********************************************************
    // frame buffer
    // ***********************************************************
    trace_frame_fifo #(
        .payload_t (sentry_pkg::trace_frame_t),
        .depth     (`SENTRY_FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (frame_valid),
        .din   (frame_in),
        .rd_en (pop),
        .dout  (head),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    // ***********************************************************
    // per-lane decode of the head frame
    // ***********************************************************
    for (genvar i = 0; i < `SENTRY_LANES; i++) begin : g_lane
        lane_decoder u_dec (
            .rec       (head[i]),
            .rs1       (rs1[i]),
            .rd        (rd[i]),
            .is_load   (is_load[i]),
            .is_store  (is_store[i]),
            .writes_rd (writes_rd[i]),
            .offset    (offset[i]),
            .wr_data   (wr_data[i])
        );
    end

    // architectural state, committed on the drain edge
    shadow_reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .commit  (pop),
        .wr_en   (writes_rd),
        .wr_addr (rd),
        .wr_data (wr_data),
        .rd_addr (rs1),
        .rd_data (rs1_val)
    );

    // drain control and registered cache requests
    dcache_req_gen u_req (
        .clk                (clk),
        .rst                (rst),
        .empty              (fifo_empty),
        .dcache_almost_full (dcache_almost_full),
        .pop                (pop),
        .base               (rs1_val),
        .offset             (offset),
        .is_load            (is_load),
        .is_store           (is_store),
        .dcache_req_valid   (dcache_req_valid),
        .dcache_req_store   (dcache_req_store),
        .dcache_req_address (dcache_req_address),
        .dcache_inst_valid  (dcache_inst_valid)
    );

endmodule

`default_nettype wire

/* rtl/dcache_req_gen.sv */
// outputs follow pop by exactly one cycle; address is not reset and only meaningful with valid
`timescale 1ns/1ps
`default_nettype none

`include "sentry_cfg.svh"

module dcache_req_gen (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     empty,
    input  wire logic                     dcache_almost_full,
    output logic                          pop,
    input  wire sentry_pkg::data_t        base   [`SENTRY_LANES-1:0],
    input  wire sentry_pkg::data_t        offset [`SENTRY_LANES-1:0],
    input  wire logic [`SENTRY_LANES-1:0] is_load,
    input  wire logic [`SENTRY_LANES-1:0] is_store,
    output logic [`SENTRY_LANES-1:0]      dcache_req_valid,
    output logic [`SENTRY_LANES-1:0]      dcache_req_store,
    output sentry_pkg::data_t             dcache_req_address [`SENTRY_LANES-1:0],
    output logic                          dcache_inst_valid
);

    logic [`SENTRY_LANES-1:0] is_mem;

    // drain one frame whenever the cache side has room
    assign pop    = !empty && !dcache_almost_full;
    assign is_mem = is_load | is_store;

    // effective addresses
    always_ff @(posedge clk) begin
        for (int l = 0; l < `SENTRY_LANES; l++) begin
            dcache_req_address[l] <= base[l] + offset[l];
        end
    end

    // strobes qualified by the drain
    always_ff @(posedge clk) begin
        if (rst) begin
            dcache_req_valid  <= '0;
            dcache_req_store  <= '0;
            dcache_inst_valid <= 1'b0;
        end else begin
            dcache_req_valid  <= is_mem & {`SENTRY_LANES{pop}};
            dcache_req_store  <= is_store & {`SENTRY_LANES{pop}};
            dcache_inst_valid <= pop;
        end
    end

    // a store lane is always a memory request
    a_store_is_valid: assert property (@(posedge clk) disable iff (rst)
        (dcache_req_store & ~dcache_req_valid) == '0);

endmodule

`default_nettype wire

/* rtl/shadow_reg_file.sv */
// one read port per lane, reads show pre-commit state; x0 writes are ignored
`timescale 1ns/1ps
`default_nettype none

`include "sentry_cfg.svh"

module shadow_reg_file (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      commit,
    input  wire logic [`SENTRY_LANES-1:0]  wr_en,
    input  wire sentry_pkg::reg_t          wr_addr [`SENTRY_LANES-1:0],
    input  wire sentry_pkg::data_t         wr_data [`SENTRY_LANES-1:0],
    input  wire sentry_pkg::reg_t          rd_addr [`SENTRY_LANES-1:0],
    output sentry_pkg::data_t              rd_data [`SENTRY_LANES-1:0]
);

    sentry_pkg::data_t regs [`SENTRY_NREGS];

    // ***********************************************************
    // write side
    // ***********************************************************

    // lanes are visited in order, so the last assignment to an index wins
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `SENTRY_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (commit) begin
            for (int l = 0; l < `SENTRY_LANES; l++) begin
                if (wr_en[l] && (wr_addr[l] != '0)) begin
                    regs[wr_addr[l]] <= wr_data[l];
                end
            end
        end
    end

    // ***********************************************************
    // read side
    // ***********************************************************

    // asynchronous, so a frame reads state from before its own writes
    always_comb begin
        for (int l = 0; l < `SENTRY_LANES; l++) begin
            rd_data[l] = regs[rd_addr[l]];
        end
    end

    // x0 must hold zero across every commit
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0);

endmodule

`default_nettype wire

/* rtl/lane_decoder.sv */
// RV32I base opcodes only; any other opcode is treated as neither memory nor write-back
`timescale 1ns/1ps
`default_nettype none

`include "sentry_cfg.svh"

module lane_decoder (
    input  wire sentry_pkg::trace_rec_t rec,
    output sentry_pkg::reg_t            rs1,
    output sentry_pkg::reg_t            rd,
    output logic                        is_load,
    output logic                        is_store,
    output logic                        writes_rd,
    output sentry_pkg::data_t           offset,
    output sentry_pkg::data_t           wr_data
);

    sentry_pkg::inst_t inst;
    logic [6:0]        opcode;
    sentry_pkg::data_t imm_i;
    sentry_pkg::data_t imm_s;
    logic              is_jump;

    assign inst   = rec.inst;
    assign opcode = inst[6:0];

    // ***********************************************************
    // register fields
    // ***********************************************************
    assign rs1 = inst[19:15];
    assign rd  = inst[11:7];

    // ***********************************************************
    // memory class and address offset
    // ***********************************************************
    assign is_load  = (opcode == sentry_pkg::OPC_LOAD);
    assign is_store = (opcode == sentry_pkg::OPC_STORE);

    // sign-extended immediates
    assign imm_i = {{(`SENTRY_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`SENTRY_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

    // non-memory lanes carry the S form, their address is never used
    assign offset = is_load ? imm_i : imm_s;

    // ***********************************************************
    // write-back
    // ***********************************************************
    assign is_jump = (opcode == sentry_pkg::OPC_JAL) ||
                     (opcode == sentry_pkg::OPC_JALR);

    always_comb begin
        case (opcode)
            sentry_pkg::OPC_LUI,
            sentry_pkg::OPC_AUIPC,
            sentry_pkg::OPC_JAL,
            sentry_pkg::OPC_JALR,
            sentry_pkg::OPC_LOAD,
            sentry_pkg::OPC_OP,
            sentry_pkg::OPC_OP_IMM: writes_rd = 1'b1;
            default:                writes_rd = 1'b0;
        endcase
    end

    // link value for jumps, core result for everything else
    assign wr_data = is_jump ? (rec.pc + `SENTRY_XLEN'(4)) : rec.result;

endmodule

`default_nettype wire

/* rtl/trace_frame_fifo.sv */
// first-word-fall-through FIFO; writes while full and reads while empty are dropped
`timescale 1ns/1ps
`default_nettype none

module trace_frame_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     wr_en,
    input  wire payload_t din,
    input  wire logic     rd_en,
    output payload_t      dout,
    output logic          full,
    output logic          empty
);

    localparam int addr_w = $clog2(depth);
    localparam int cnt_w  = $clog2(depth + 1);
    localparam logic [addr_w-1:0] last_ptr = addr_w'(depth - 1);

    payload_t          mem [depth];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              wr_ok;
    logic              rd_ok;

    // pointers wrap at depth, which need not be a power of two
    function automatic logic [addr_w-1:0] next_ptr(input logic [addr_w-1:0] p);
        if (p == last_ptr) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);

    // head is visible as soon as it is written
    assign dout  = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the trace source has no ready and must watch full
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        full |-> !wr_en);

    // drain logic must respect empty
    a_no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
        empty |-> !rd_en);

endmodule

`default_nettype wire

/* rtl/sentry_pkg.sv */
// shared types and RV32 opcodes; record layout is {inst, result, pc}, msb first
`default_nettype none

`include "sentry_cfg.svh"

package sentry_pkg;

    // basic words
    typedef logic [`SENTRY_XLEN-1:0]           data_t;
    typedef logic [$clog2(`SENTRY_NREGS)-1:0] reg_t;
    typedef logic [31:0]                       inst_t;

    // one retired instruction as reported by the main core
    typedef struct packed {
        inst_t inst;
        data_t result;
        data_t pc;
    } trace_rec_t;

    // lane 0 sits in the low bits
    typedef trace_rec_t [`SENTRY_LANES-1:0] trace_frame_t;

    // ***********************************************************
    // RV32I major opcodes
    // ***********************************************************
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

/* include/sentry_cfg.svh */
// sizing for the sentry front end; LANES must stay 4 and FIFO depth at least 2
`ifndef SENTRY_CFG_SVH
`define SENTRY_CFG_SVH

// ***********************************************************
// frame geometry
// ***********************************************************

// retired-instruction records per frame
`define SENTRY_LANES      4

// data and address width, RV32 only
`define SENTRY_XLEN       32

// architectural integer registers
`define SENTRY_NREGS      32

// ***********************************************************
// buffering
// ***********************************************************

// whole frames held between the trace port and the decoders
`define SENTRY_FIFO_DEPTH 16

`endif
